// ==== spi_xip.f ====
logic/xip_pkg.sv
logic/xip_ar_capture.sv
logic/spi_read_engine.sv
logic/rdata_packer.sv
logic/spi_xip_top.sv
bench/spi_flash_model.sv
bench/spi_xip_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module spi_xip_tb -f spi_xip.f -o spi_xip_sim \
    && ./obj_dir/spi_xip_sim | tee sim.log \
    && grep -qF '** PASS **' sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== bench/spi_xip_tb.sv ====
module spi_xip_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int         SCK_DIV = 4;
    localparam int         N_ROWS  = 8;
    localparam logic [1:0] OKAY    = 2'b00;
    localparam logic [1:0] SLVERR  = 2'b10;

    // one request per row; ovl rows are sent while the previous burst still returns data
    logic [31:0] row_addr  [N_ROWS] = '{32'h0000_0100, 32'h0000_1230, 32'h0000_abc0,
                                        32'h0000_0200, 32'h0000_0302, 32'h0000_0400,
                                        32'h0012_3400, 32'h0012_5600};
    logic [7:0]  row_len   [N_ROWS] = '{8'd0, 8'd7, 8'd15, 8'd2, 8'd1, 8'd3, 8'd7, 8'd3};
    logic [1:0]  row_burst [N_ROWS] = '{2'b01, 2'b01, 2'b01, 2'b00, 2'b01, 2'b01, 2'b01, 2'b01};
    logic [2:0]  row_size  [N_ROWS] = '{3'd2, 3'd2, 3'd2, 3'd2, 3'd2, 3'd1, 3'd2, 3'd2};
    logic        row_bp    [N_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};
    logic [2:0]  row_err   [N_ROWS] = '{3'b000, 3'b000, 3'b000, 3'b100, 3'b010, 3'b001,
                                        3'b000, 3'b000};
    logic        row_ovl   [N_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    logic           amba_clk = 1'b0;
    logic           amba_resetn;
    logic [31:0]    s_axi_araddr_i;
    logic [1:0]     s_axi_arburst_i;
    logic [7:0]     s_axi_arlen_i;
    logic [2:0]     s_axi_arsize_i;
    logic           s_axi_arvalid_i;
    logic           s_axi_arready_o;
    logic [31:0]    s_axi_rdata_o;
    logic [1:0]     s_axi_rresp_o;
    logic           s_axi_rlast_o;
    logic           s_axi_rvalid_o;
    logic           s_axi_rready_i;
    logic           spi_ss_o;
    logic           spi_sck_o;
    logic           spi_mosi_o;
    logic           spi_miso_i;
    logic [2:0]     xip_err_o;

    logic               quiet;          // flash must stay deselected
    int                 flash_faults;
    int                 errors;
    int                 cycle;
    int                 limit;
    int                 total;
    int                 row_base;       // failures counted before the current row
    int                 ar_idx;         // next row to send
    int                 rsp_idx;        // row whose beats are expected
    int                 beat;
    int                 err_row;
    logic               ar_hs;          // handshake happens at the coming edge
    logic               err_arm;
    logic               stall_q;
    logic               timed_out;
    logic [N_ROWS-1:0]  issued;
    logic [31:0]        rdata_q;
    logic [31:0]        lcg_state;
    logic [31:0]        exp_data;
    logic [1:0]         exp_resp;
    logic               exp_last;

    always #2 amba_clk = ~amba_clk;

    spi_xip_top #(.SCK_DIV(SCK_DIV)) u_spi_xip_top
    (
        .amba_clk        (amba_clk),
        .amba_resetn     (amba_resetn),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arburst_i (s_axi_arburst_i),
        .s_axi_arlen_i   (s_axi_arlen_i),
        .s_axi_arsize_i  (s_axi_arsize_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .s_axi_rdata_o   (s_axi_rdata_o),
        .s_axi_rresp_o   (s_axi_rresp_o),
        .s_axi_rlast_o   (s_axi_rlast_o),
        .s_axi_rvalid_o  (s_axi_rvalid_o),
        .s_axi_rready_i  (s_axi_rready_i),
        .spi_ss_o        (spi_ss_o),
        .spi_sck_o       (spi_sck_o),
        .spi_mosi_o      (spi_mosi_o),
        .spi_miso_i      (spi_miso_i),
        .xip_err_o       (xip_err_o)
    );

    spi_flash_model u_flash
    (
        .spi_ss_i    (spi_ss_o),
        .spi_sck_i   (spi_sck_o),
        .spi_mosi_i  (spi_mosi_o),
        .spi_miso_o  (spi_miso_i),
        .quiet_i     (quiet),
        .fault_cnt_o (flash_faults)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'hA5;
    endfunction

    // lowest address in bits 7:0
    function automatic logic [31:0] expected_word(input logic [23:0] a);
        return {flash_byte(a + 24'd3), flash_byte(a + 24'd2), flash_byte(a + 24'd1),
                flash_byte(a)};
    endfunction

    function automatic logic ready_to_issue(input int j);
        if (rsp_idx == j)
            return 1'b1;
        return row_ovl[j] && rsp_idx == j - 1 && beat > 0;
    endfunction

    task drive_inputs();
        if (ar_hs)
        begin
            s_axi_arvalid_i <= 1'b0;
            ar_hs  = 1'b0;
            ar_idx = ar_idx + 1;
        end
        else if (!s_axi_arvalid_i && ar_idx < N_ROWS && ready_to_issue(ar_idx))
        begin
            s_axi_araddr_i  <= row_addr[ar_idx];
            s_axi_arlen_i   <= row_len[ar_idx];
            s_axi_arburst_i <= row_burst[ar_idx];
            s_axi_arsize_i  <= row_size[ar_idx];
            s_axi_arvalid_i <= 1'b1;
        end
        lcg_state = lcg_next(lcg_state);
        if (rsp_idx < N_ROWS && row_bp[rsp_idx])
            s_axi_rready_i <= lcg_state[16];
        else
            s_axi_rready_i <= 1'b1;
    endtask

    task finish_row();
        if (rsp_idx + 1 < N_ROWS && row_ovl[rsp_idx + 1] && !issued[rsp_idx + 1])
        begin
            $display("test %0d: next request was not accepted during this burst", rsp_idx);
            errors = errors + 1;
        end
        total = errors + flash_faults;
        $display("test %0d: %0d beats, %s", rsp_idx, beat + 1,
                 (total == row_base) ? "ok" : "failed");
        row_base = total;
        rsp_idx  = rsp_idx + 1;
        beat     = 0;
        quiet    = (rsp_idx < N_ROWS) ? (row_err[rsp_idx] != 3'b000) : 1'b0;
    endtask

    task check_beat();
        exp_resp = (row_err[rsp_idx] != 3'b000) ? SLVERR : OKAY;
        exp_data = (row_err[rsp_idx] != 3'b000) ? 32'h0
                 : expected_word(row_addr[rsp_idx][23:0] + 24'(beat * 4));
        exp_last = beat == int'(row_len[rsp_idx]);
        if (s_axi_rdata_o !== exp_data)
        begin
            $display("Fail test %0d beat %0d s_axi_rdata_o: expected %h, got %h",
                     rsp_idx, beat, exp_data, s_axi_rdata_o);
            errors = errors + 1;
        end
        if (s_axi_rresp_o !== exp_resp)
        begin
            $display("Fail test %0d beat %0d s_axi_rresp_o: expected %h, got %h",
                     rsp_idx, beat, exp_resp, s_axi_rresp_o);
            errors = errors + 1;
        end
        if (s_axi_rlast_o !== exp_last)
        begin
            $display("Fail test %0d beat %0d s_axi_rlast_o: expected %h, got %h",
                     rsp_idx, beat, exp_last, s_axi_rlast_o);
            errors = errors + 1;
        end
        if (exp_last)
            finish_row();
        else
            beat = beat + 1;
    endtask

    task check_outputs();
        if (err_arm)
        begin
            if (xip_err_o !== row_err[err_row])
            begin
                $display("Fail test %0d xip_err_o: expected %h, got %h",
                         err_row, row_err[err_row], xip_err_o);
                errors = errors + 1;
            end
            err_arm = 1'b0;
        end
        else if (xip_err_o !== 3'b000)
        begin
            $display("Fail xip_err_o outside a pulse: expected %h, got %h", 3'b000, xip_err_o);
            errors = errors + 1;
        end
        if (s_axi_arvalid_i && s_axi_arready_o)
        begin
            ar_hs           = 1'b1;
            issued[ar_idx]  = 1'b1;
            err_arm         = 1'b1;
            err_row         = ar_idx;
        end
        // a stalled beat must hold still
        if (stall_q && (!s_axi_rvalid_o || s_axi_rdata_o !== rdata_q))
        begin
            $display("Fail s_axi_rdata_o under back-pressure: expected %h, got %h",
                     rdata_q, s_axi_rdata_o);
            errors = errors + 1;
        end
        stall_q = s_axi_rvalid_o && !s_axi_rready_i;
        rdata_q = s_axi_rdata_o;
        if (s_axi_rvalid_o && s_axi_rready_i && rsp_idx < N_ROWS)
            check_beat();
    endtask

    initial
    begin
        amba_resetn     = 1'b0;
        s_axi_araddr_i  = '0;
        s_axi_arburst_i = '0;
        s_axi_arlen_i   = '0;
        s_axi_arsize_i  = '0;
        s_axi_arvalid_i = 1'b0;
        s_axi_rready_i  = 1'b0;
        quiet           = 1'b0;
        errors          = 0;
        cycle           = 0;
        row_base        = 0;
        ar_idx          = 0;
        rsp_idx         = 0;
        beat            = 0;
        err_row         = 0;
        ar_hs           = 1'b0;
        err_arm         = 1'b0;
        stall_q         = 1'b0;
        timed_out       = 1'b0;
        issued          = '0;
        rdata_q         = '0;
        lcg_state       = 32'h6e42_5e5d;
        limit           = 0;
        for (int i = 0; i < N_ROWS; i++)
            limit = limit + (int'(row_len[i]) + 1) * 4 * (8 * SCK_DIV + 2);
        limit = 2 * limit + 200 * N_ROWS;

        repeat (3) @(posedge amba_clk);
        amba_resetn <= 1'b1;
        @(negedge amba_clk);
        if (s_axi_arready_o !== 1'b1 || s_axi_rvalid_o !== 1'b0)
        begin
            $display("Fail arready/rvalid after reset: expected 1/0, got %h/%h",
                     s_axi_arready_o, s_axi_rvalid_o);
            errors = errors + 1;
        end
        if (spi_ss_o !== 1'b1 || spi_sck_o !== 1'b0 || xip_err_o !== 3'b000)
        begin
            $display("Fail ss/sck/xip_err_o after reset: expected 1/0/0, got %h/%h/%h",
                     spi_ss_o, spi_sck_o, xip_err_o);
            errors = errors + 1;
        end

        while (rsp_idx < N_ROWS && !timed_out)
        begin
            @(posedge amba_clk);
            drive_inputs();
            @(negedge amba_clk);
            check_outputs();
            cycle = cycle + 1;
            if (cycle >= limit)
            begin
                $display("timeout: test %0d did not finish within %0d cycles", rsp_idx, limit);
                timed_out = 1'b1;
            end
        end

        total = errors + flash_faults;
        $display("%0d of %0d tests finished, %0d failures, %0d cycles",
                 rsp_idx, N_ROWS, total, cycle);
        if (total == 0 && !timed_out)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== bench/spi_flash_model.sv ====
module spi_flash_model
(
    input  logic    spi_ss_i,
    input  logic    spi_sck_i,
    input  logic    spi_mosi_i,
    output logic    spi_miso_o,
    input  logic    quiet_i,            // current request must not reach the flash
    output int      fault_cnt_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0]    cmd_shift;          // opcode then address, MSB first
    logic [23:0]    rd_addr;
    logic [7:0]     cur_byte;
    int             rise_cnt;           // sck rising edges since select
    int             sel_faults;         // selects during a quiet request
    int             cmd_faults;         // opcodes other than a standard read

    function automatic logic [7:0] mem_byte(input logic [23:0] a);
        return a[7:0] ^ a[15:8] ^ 8'hA5;
    endfunction

    assign fault_cnt_o = sel_faults + cmd_faults;

    initial
    begin
        spi_miso_o = 1'b0;
        sel_faults = 0;
        cmd_faults = 0;
        rise_cnt   = 0;
        cmd_shift  = '0;
        rd_addr    = '0;
        cur_byte   = '0;
    end

    always @(negedge spi_ss_i)
    begin
        if (quiet_i)
        begin
            $display("flash: chip select went low for a request that must get no SPI traffic");
            sel_faults = sel_faults + 1;
        end
    end

    // mode 0 sampling of MOSI on the rising edge
    always @(posedge spi_sck_i or posedge spi_ss_i)
    begin
        if (spi_ss_i)
        begin
            rise_cnt = 0;               // count restarts once select is released
        end
        else
        begin
            if (rise_cnt < 32)
                cmd_shift = {cmd_shift[30:0], spi_mosi_i};
            rise_cnt = rise_cnt + 1;
            if (rise_cnt == 8 && cmd_shift[7:0] != 8'h03)
            begin
                $display("flash: command %h is not a standard read", cmd_shift[7:0]);
                cmd_faults = cmd_faults + 1;
            end
            if (rise_cnt == 32)
                rd_addr = cmd_shift[23:0];
        end
    end

    // next data bit goes out on the falling edge
    always @(negedge spi_sck_i)
    begin
        if (!spi_ss_i && rise_cnt >= 32)
        begin
            cur_byte   = mem_byte(rd_addr + 24'((rise_cnt - 32) / 8));
            spi_miso_o = cur_byte[7 - ((rise_cnt - 32) % 8)];
        end
    end

endmodule

// ==== logic/spi_xip_top.sv ====
module spi_xip_top
#(
    parameter int SCK_DIV = 4
)
(
    input  logic           amba_clk,
    input  logic           amba_resetn,

    // AR channel
    input  logic [31:0]    s_axi_araddr_i,
    input  logic [1:0]     s_axi_arburst_i,
    input  logic [7:0]     s_axi_arlen_i,
    input  logic [2:0]     s_axi_arsize_i,
    input  logic           s_axi_arvalid_i,
    output logic           s_axi_arready_o,

    // R channel
    output logic [31:0]    s_axi_rdata_o,
    output logic [1:0]     s_axi_rresp_o,
    output logic           s_axi_rlast_o,
    output logic           s_axi_rvalid_o,
    input  logic           s_axi_rready_i,

    // flash pins, mode 0
    output logic           spi_ss_o,
    output logic           spi_sck_o,
    output logic           spi_mosi_o,
    input  logic           spi_miso_i,

    output logic [2:0]     xip_err_o
);

    logic                              cmd_start;
    logic [xip_pkg::ADDR_W-1:0]        cmd_addr;
    logic [xip_pkg::BYTE_CNT_W-1:0]    cmd_bytes;
    logic                              err_start;
    logic [7:0]                        err_beats;
    logic                              resp_idle;
    logic                              byte_valid;
    logic [7:0]                        byte_data;
    logic                              byte_last;
    logic                              word_hold;

    xip_ar_capture u_ar_capture
    (
        .amba_clk        (amba_clk),
        .amba_resetn     (amba_resetn),
        .s_axi_araddr_i  (s_axi_araddr_i),
        .s_axi_arburst_i (s_axi_arburst_i),
        .s_axi_arlen_i   (s_axi_arlen_i),
        .s_axi_arsize_i  (s_axi_arsize_i),
        .s_axi_arvalid_i (s_axi_arvalid_i),
        .s_axi_arready_o (s_axi_arready_o),
        .resp_idle_i     (resp_idle),
        .cmd_start_o     (cmd_start),
        .cmd_addr_o      (cmd_addr),
        .cmd_bytes_o     (cmd_bytes),
        .err_start_o     (err_start),
        .err_beats_o     (err_beats),
        .xip_err_o       (xip_err_o)
    );

    spi_read_engine #(.SCK_DIV(SCK_DIV)) u_read_engine
    (
        .amba_clk     (amba_clk),
        .amba_resetn  (amba_resetn),
        .cmd_start_i  (cmd_start),
        .cmd_addr_i   (cmd_addr),
        .cmd_bytes_i  (cmd_bytes),
        .word_hold_i  (word_hold),
        .byte_valid_o (byte_valid),
        .byte_data_o  (byte_data),
        .byte_last_o  (byte_last),
        .spi_ss_o     (spi_ss_o),
        .spi_sck_o    (spi_sck_o),
        .spi_mosi_o   (spi_mosi_o),
        .spi_miso_i   (spi_miso_i)
    );

    rdata_packer u_packer
    (
        .amba_clk       (amba_clk),
        .amba_resetn    (amba_resetn),
        .byte_valid_i   (byte_valid),
        .byte_data_i    (byte_data),
        .byte_last_i    (byte_last),
        .err_start_i    (err_start),
        .err_beats_i    (err_beats),
        .word_hold_o    (word_hold),
        .resp_idle_o    (resp_idle),
        .s_axi_rdata_o  (s_axi_rdata_o),
        .s_axi_rresp_o  (s_axi_rresp_o),
        .s_axi_rlast_o  (s_axi_rlast_o),
        .s_axi_rvalid_o (s_axi_rvalid_o),
        .s_axi_rready_i (s_axi_rready_i)
    );

endmodule

// ==== logic/rdata_packer.sv ====
module rdata_packer
(
    input  logic           amba_clk,
    input  logic           amba_resetn,

    input  logic           byte_valid_i,
    input  logic [7:0]     byte_data_i,
    input  logic           byte_last_i,
    input  logic           err_start_i,
    input  logic [7:0]     err_beats_i,

    output logic           word_hold_o,
    output logic           resp_idle_o,

    output logic [31:0]    s_axi_rdata_o,
    output logic [1:0]     s_axi_rresp_o,
    output logic           s_axi_rlast_o,
    output logic           s_axi_rvalid_o,
    input  logic           s_axi_rready_i
);

    logic [31:0]    word_q;
    logic [1:0]     lane_cnt;       // next byte lane, lowest address first
    logic           rvalid_q;
    logic           rlast_q;
    logic           err_active;     // sending SLVERR beats
    logic [7:0]     err_cnt;        // error beats left minus one
    logic           idle_q;
    logic           r_fire;

    assign r_fire = rvalid_q & s_axi_rready_i;

    always_ff @(posedge amba_clk or negedge amba_resetn)
    begin
        if (!amba_resetn)
        begin
            lane_cnt   <= '0;
            rvalid_q   <= 1'b0;
            rlast_q    <= 1'b0;
            err_active <= 1'b0;
            err_cnt    <= '0;
            idle_q     <= 1'b1;
        end
        else if (err_start_i)
        begin
            err_active <= 1'b1;
            err_cnt    <= err_beats_i;
            rvalid_q   <= 1'b1;     // first error beat right away
            idle_q     <= 1'b0;
        end
        else if (err_active)
        begin
            if (r_fire)
            begin
                if (err_cnt == '0)
                begin
                    err_active <= 1'b0;
                    rvalid_q   <= 1'b0;
                    idle_q     <= 1'b1;
                end
                else
                begin
                    err_cnt <= err_cnt - 1'b1;
                end
            end
        end
        else
        begin
            if (byte_valid_i)
            begin
                lane_cnt <= lane_cnt + 1'b1;
                idle_q   <= 1'b0;
                if (lane_cnt == 2'd3)
                begin
                    rvalid_q <= 1'b1;       // word complete
                    rlast_q  <= byte_last_i;
                end
            end
            if (r_fire)
            begin
                rvalid_q <= 1'b0;
                if (rlast_q)
                    idle_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge amba_clk)
    begin
        if (byte_valid_i)
            word_q[{lane_cnt, 3'b000} +: 8] <= byte_data_i;
    end

    assign word_hold_o    = rvalid_q;       // engine waits at next byte boundary
    assign resp_idle_o    = idle_q;
    assign s_axi_rvalid_o = rvalid_q;
    assign s_axi_rdata_o  = err_active ? 32'h0 : word_q;
    assign s_axi_rresp_o  = err_active ? xip_pkg::RESP_SLVERR : xip_pkg::RESP_OKAY;
    assign s_axi_rlast_o  = err_active ? (err_cnt == '0) : rlast_q;

    a_r_stable: assert property (@(posedge amba_clk) disable iff (!amba_resetn)
        s_axi_rvalid_o && !s_axi_rready_i |=>
            s_axi_rvalid_o && $stable(s_axi_rdata_o) && $stable(s_axi_rresp_o)
            && $stable(s_axi_rlast_o));

endmodule

// ==== logic/spi_read_engine.sv ====
module spi_read_engine
#(
    parameter int SCK_DIV = 4                       // even, at least 2
)
(
    input  logic                              amba_clk,
    input  logic                              amba_resetn,

    input  logic                              cmd_start_i,
    input  logic [xip_pkg::ADDR_W-1:0]        cmd_addr_i,
    input  logic [xip_pkg::BYTE_CNT_W-1:0]    cmd_bytes_i,
    input  logic                              word_hold_i,

    output logic                              byte_valid_o,
    output logic [7:0]                        byte_data_o,
    output logic                              byte_last_o,

    output logic                              spi_ss_o,
    output logic                              spi_sck_o,
    output logic                              spi_mosi_o,
    input  logic                              spi_miso_i
);

    localparam int HALF  = SCK_DIV / 2;
    localparam int DIV_W = $clog2(SCK_DIV);

    localparam logic [2:0] ST_IDLE  = 3'd0;
    localparam logic [2:0] ST_FRAME = 3'd1;         // opcode and address out
    localparam logic [2:0] ST_GAP   = 3'd2;         // byte boundary, hold check
    localparam logic [2:0] ST_DATA  = 3'd3;
    localparam logic [2:0] ST_DONE  = 3'd4;

    logic [2:0]                        state;
    logic [DIV_W-1:0]                  div_cnt;     // position inside one bit cell
    logic [4:0]                        bit_cnt;
    logic [xip_pkg::BYTE_CNT_W-1:0]    byte_cnt;    // bytes left minus one
    xip_pkg::spi_frame_u               frame_q;
    logic [7:0]                        rx_shift;
    logic                              sck_q;
    logic                              ss_q;
    logic                              byte_valid_q;
    logic                              byte_last_q;
    logic                              rise_tick;
    logic                              fall_tick;
    logic                              bit_end;

    assign rise_tick = div_cnt == DIV_W'(HALF - 1);
    assign fall_tick = div_cnt == DIV_W'(SCK_DIV - 1);
    assign bit_end   = (state == ST_FRAME) ? (bit_cnt == 5'd31) : (bit_cnt == 5'd7);

    always_ff @(posedge amba_clk or negedge amba_resetn)
    begin
        if (!amba_resetn)
        begin
            state        <= ST_IDLE;
            div_cnt      <= '0;
            bit_cnt      <= '0;
            byte_cnt     <= '0;
            sck_q        <= 1'b0;
            ss_q         <= 1'b1;
            byte_valid_q <= 1'b0;
        end
        else
        begin
            byte_valid_q <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (cmd_start_i)
                    begin
                        ss_q     <= 1'b0;
                        div_cnt  <= '0;
                        bit_cnt  <= '0;
                        byte_cnt <= cmd_bytes_i;
                        state    <= ST_FRAME;
                    end
                end
                ST_FRAME, ST_DATA:
                begin
                    if (rise_tick)
                    begin
                        sck_q   <= 1'b1;
                        div_cnt <= div_cnt + 1'b1;
                        if (state == ST_DATA && bit_cnt == 5'd7)
                        begin
                            byte_valid_q <= 1'b1;
                            if (byte_cnt == '0)
                                state <= ST_DONE;   // flash already sampled, cut the pulse
                        end
                    end
                    else if (fall_tick)
                    begin
                        sck_q   <= 1'b0;
                        div_cnt <= '0;
                        if (bit_end)
                        begin
                            bit_cnt <= '0;
                            state   <= ST_GAP;
                            if (state == ST_DATA)
                                byte_cnt <= byte_cnt - 1'b1;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                    else
                    begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                ST_GAP:
                begin
                    if (!word_hold_i)       // packer has room for the next byte
                        state <= ST_DATA;
                end
                ST_DONE:
                begin
                    // drop sck first, release chip select a cycle later
                    if (sck_q)
                    begin
                        sck_q <= 1'b0;
                    end
                    else
                    begin
                        ss_q  <= 1'b1;
                        state <= ST_IDLE;
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge amba_clk)
    begin
        if (state == ST_IDLE && cmd_start_i)
        begin
            frame_q.cmd.opcode <= xip_pkg::OPCODE_READ;
            frame_q.cmd.addr   <= cmd_addr_i;
        end
        else if (state == ST_FRAME && fall_tick)
        begin
            frame_q.word <= {frame_q.word[30:0], 1'b0};  // next bit on falling edge
        end
        if (state == ST_DATA && rise_tick)
        begin
            rx_shift    <= {rx_shift[6:0], spi_miso_i};   // MSB first
            byte_last_q <= byte_cnt == '0;
        end
    end

    assign spi_ss_o     = ss_q;
    assign spi_sck_o    = sck_q;
    assign spi_mosi_o   = (state == ST_FRAME) ? frame_q.word[31] : 1'b0;
    assign byte_valid_o = byte_valid_q;
    assign byte_data_o  = rx_shift;
    assign byte_last_o  = byte_last_q;

    // capture must wait for the previous transaction to end
    a_start_ss_high: assert property (@(posedge amba_clk) disable iff (!amba_resetn)
        cmd_start_i |-> spi_ss_o);

endmodule

// ==== logic/xip_ar_capture.sv ====
module xip_ar_capture
(
    input  logic                              amba_clk,
    input  logic                              amba_resetn,

    input  logic [31:0]                       s_axi_araddr_i,
    input  logic [1:0]                        s_axi_arburst_i,
    input  logic [7:0]                        s_axi_arlen_i,
    input  logic [2:0]                        s_axi_arsize_i,
    input  logic                              s_axi_arvalid_i,
    output logic                              s_axi_arready_o,

    input  logic                              resp_idle_i,
    output logic                              cmd_start_o,
    output logic [xip_pkg::ADDR_W-1:0]        cmd_addr_o,
    output logic [xip_pkg::BYTE_CNT_W-1:0]    cmd_bytes_o,
    output logic                              err_start_o,
    output logic [7:0]                        err_beats_o,
    output logic [2:0]                        xip_err_o
);

    logic                          cmd_full;        // one command held
    logic                          cmd_is_err;      // held command is unsupported
    logic [xip_pkg::ADDR_W-1:0]    cmd_addr_q;
    logic [7:0]                    cmd_len_q;       // arlen of held command
    logic                          resp_pending;    // issued, response not finished yet
    logic                          resp_idle_d;
    logic [2:0]                    err_q;
    logic [2:0]                    ar_err;
    logic                          ar_fire;
    logic                          issue;

    assign ar_fire = s_axi_arvalid_i & ~cmd_full;
    assign issue   = cmd_full & resp_idle_i & ~resp_pending;

    always_comb
    begin
        ar_err                     = '0;
        ar_err[xip_pkg::ERR_BURST] = s_axi_arburst_i != xip_pkg::BURST_INCR;
        ar_err[xip_pkg::ERR_ALIGN] = s_axi_araddr_i[1:0] != 2'b00;
        ar_err[xip_pkg::ERR_SIZE]  = s_axi_arsize_i != xip_pkg::SIZE_WORD;
    end

    always_ff @(posedge amba_clk or negedge amba_resetn)
    begin
        if (!amba_resetn)
        begin
            cmd_full     <= 1'b0;
            cmd_is_err   <= 1'b0;
            resp_pending <= 1'b0;
            resp_idle_d  <= 1'b1;
            err_q        <= '0;
        end
        else
        begin
            resp_idle_d <= resp_idle_i;
            err_q       <= ar_fire ? ar_err : 3'b000;    // one cycle pulse
            if (ar_fire)
            begin
                cmd_full   <= 1'b1;
                cmd_is_err <= |ar_err;
            end
            else if (issue)
            begin
                cmd_full <= 1'b0;
            end
            // the packer's idle rising again means the last response is done
            if (issue)
                resp_pending <= 1'b1;
            else if (resp_idle_i && !resp_idle_d)
                resp_pending <= 1'b0;
        end
    end

    always_ff @(posedge amba_clk)
    begin
        if (ar_fire)
        begin
            cmd_addr_q <= s_axi_araddr_i[xip_pkg::ADDR_W-1:0];
            cmd_len_q  <= s_axi_arlen_i;
        end
    end

    assign s_axi_arready_o = ~cmd_full;
    assign cmd_start_o     = issue & ~cmd_is_err;
    assign err_start_o     = issue & cmd_is_err;
    assign cmd_addr_o      = cmd_addr_q;
    assign cmd_bytes_o     = xip_pkg::BYTE_CNT_W'({cmd_len_q, 2'b11});  // 4*(arlen+1)-1
    assign err_beats_o     = cmd_len_q;
    assign xip_err_o       = err_q;

    // the packer leaves idle right after an error start
    a_err_busy: assert property (@(posedge amba_clk) disable iff (!amba_resetn)
        err_start_o |=> !resp_idle_i);

endmodule

// ==== logic/xip_pkg.sv ====
package xip_pkg;

    // flash side address and transfer sizing
    localparam int ADDR_W     = 24;                 // 16 MB flash window
    localparam int BYTE_CNT_W = 10;                 // up to 256 beats of 4 bytes, minus one

    // standard read command
    localparam logic [7:0] OPCODE_READ = 8'h03;

    // AXI encodings
    localparam logic [1:0] BURST_INCR  = 2'b01;
    localparam logic [2:0] SIZE_WORD   = 3'b010;    // 4 bytes per beat
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // bit positions in the error vector
    localparam int ERR_BURST = 2;                   // burst type other than INCR
    localparam int ERR_ALIGN = 1;                   // address not word aligned
    localparam int ERR_SIZE  = 0;                   // beat size other than 4 bytes

    // Outgoing SPI frame. The engine fills it through the command view
    // and shifts it out MSB first through the word view.
    typedef union packed
    {
        struct packed
        {
            logic [7:0]        opcode;              // sent first
            logic [ADDR_W-1:0] addr;                // big endian on the wire
        } cmd;
        logic [31:0] word;                          // shift view
    } spi_frame_u;

endpackage
